// ==== all.f ====
+incdir+verilog
+incdir+tb
verilog/game_pkg.sv
verilog/frame_timer.sv
verilog/mode_control.sv
verilog/accel_sampler.sv
verilog/player_motion.sv
verilog/enemy_patrol.sv
verilog/pixel_compositor.sv
verilog/game_top.sv
tb/game_tb.sv

// ==== tb/game_tb_checks.svh ====
`ifndef GAME_TB_CHECKS_SVH
`define GAME_TB_CHECKS_SVH

// Highest corner that keeps a box on screen
localparam int H_LIMIT = `GAME_H_LAST - `GAME_SPRITE_SIZE;
localparam int V_LIMIT = `GAME_V_LAST - `GAME_SPRITE_SIZE;

// Model state as it should stand after the latest rising edge
logic        m_eof;
int          m_frame_cnt;
logic        m_c_prev;
regime_e     m_regime;
accel_t      m_accel_sampled;
int          m_player_h;
int          m_player_v;
int          m_enemy_h;
patrol_dir_e m_dir;
rgb_t        m_rgb;

task automatic model_reset();
  m_eof           = 1'b0;
  m_frame_cnt     = 0;
  m_c_prev        = 1'b0;
  m_regime        = REGIME_BUTTONS;
  m_accel_sampled = '0;
  m_player_h      = `GAME_PLAYER_H0;
  m_player_v      = `GAME_PLAYER_V0;
  m_enemy_h       = `GAME_ENEMY_H0;
  m_dir           = DIR_LEFT;
  m_rgb           = '0;
endtask

function automatic int clamp(int c, int c_max);
  if (c < 0)
    return 0;
  return (c > c_max) ? c_max : c;
endfunction

// Both box edges count as inside
function automatic logic in_square(int ph, int pv, int bh, int bv);
  return (ph >= bh) && (ph <= bh + `GAME_SPRITE_SIZE) &&
         (pv >= bv) && (pv <= bv + `GAME_SPRITE_SIZE);
endfunction

function automatic rgb_t pixel_colour(int ph, int pv, logic [2:0] s);
  rgb_t c;
  if (in_square(ph, pv, m_player_h, m_player_v)) begin
    c = rgb_t'(`GAME_PLAYER_RGB);
  end else if (in_square(ph, pv, m_enemy_h, `GAME_ENEMY_V)) begin
    c = rgb_t'(`GAME_ENEMY_RGB);
  end else begin
    c.red   = s[0] ? 4'(`GAME_BG_LEVEL) : 4'd0;
    c.green = s[1] ? 4'(`GAME_BG_LEVEL) : 4'd0;
    c.blue  = s[2] ? 4'(`GAME_BG_LEVEL) : 4'd0;
  end
  return c;
endfunction

// Advances the model over one rising edge with the inputs now driven
task automatic model_edge();
  logic              act;
  logic signed [7:0] sx;
  logic signed [7:0] sy;
  int                dh;
  int                dv;
  rgb_t              next_rgb;
  act      = m_eof && (m_frame_cnt == 0);
  next_rgb = pixel_colour(int'(h_coord[9:0]), int'(v_coord), sw);  // Old positions
  sx       = accel_data.x + 8'(`GAME_ACCEL_X_CORR);
  sy       = accel_data.y + 8'(`GAME_ACCEL_Y_CORR);
  if (m_regime == REGIME_BUTTONS) begin
    dh = buttons.left ? -1 : (buttons.right ? 1 : 0);
    dv = buttons.up ? -1 : (buttons.down ? 1 : 0);
  end else begin
    dh = (sy > 0) ? -1 : ((sy < 0) ? 1 : 0);
    dv = (sx < 0) ? -1 : ((sx > 0) ? 1 : 0);
  end
  if (act) begin
    m_player_h      = clamp(m_player_h + dh, H_LIMIT);
    m_player_v      = clamp(m_player_v + dv, V_LIMIT);
    m_accel_sampled = {sx, sy};
    if (m_dir == DIR_LEFT && m_enemy_h == 0) begin
      m_dir = DIR_RIGHT;  // Waits one step at the left edge
    end else if (m_dir == DIR_LEFT) begin
      m_enemy_h--;
    end else if (m_enemy_h + 1 >= H_LIMIT) begin
      m_enemy_h = H_LIMIT;
      m_dir     = DIR_LEFT;
    end else begin
      m_enemy_h++;
    end
  end
  if (m_eof)
    m_frame_cnt = (m_frame_cnt + 1) % (`GAME_FRAMES_PER_ACTION + 1);
  if (button_c && !m_c_prev)
    m_regime = (m_regime == REGIME_BUTTONS) ? REGIME_ACCEL : REGIME_BUTTONS;
  m_c_prev = button_c;
  m_eof    = (h_coord[9:0] == `GAME_H_LAST) && (v_coord == `GAME_V_LAST);
  m_rgb    = next_rgb;
endtask

task automatic report_mismatch(string msg);
  $display("Fail at %0t: %s", $time, msg);
  $display("Test failed");
  $fatal(1, "Stopped at first mismatch");
endtask

task automatic check_rgb(rgb_t got, rgb_t exp);
  if (got !== exp)
    report_mismatch($sformatf("rgb is %03h, expected %03h", got, exp));
endtask

task automatic check_accel(accel_t got, accel_t exp);
  if (got !== exp)
    report_mismatch($sformatf("accel_end_of_frame is %04h, expected %04h", got, exp));
endtask

task automatic check_regime(regime_e got, regime_e exp);
  if (got !== exp)
    report_mismatch($sformatf("regime status is %0d, expected %0d", got, exp));
endtask

task automatic compare_outputs();
  check_rgb(rgb, m_rgb);
  check_accel(accel_end_of_frame, m_accel_sampled);
  check_regime(regime_e'(demo_regime_status), m_regime);
endtask

`endif

// ==== tb/game_tb.sv ====
`timescale 1ns/10ps
`include "game_defs.svh"

module game_tb;
  import game_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int N_FRAMES     = 400;
  localparam int FRAME_CYCLES = 30;  // Room for the 25 cycles of a frame
  localparam int SLOTS        = 24;

  // Corner offsets on the box edges then just outside
  localparam int PROBE_DH [8] = '{0, `GAME_SPRITE_SIZE, 0, `GAME_SPRITE_SIZE,
                                  -1, `GAME_SPRITE_SIZE + 1, 0, `GAME_SPRITE_SIZE};
  localparam int PROBE_DV [8] = '{0, 0, `GAME_SPRITE_SIZE, `GAME_SPRITE_SIZE,
                                  0, `GAME_SPRITE_SIZE, -1, `GAME_SPRITE_SIZE + 1};

  logic        pixel_clk;
  logic        rst_n;
  logic        button_c;
  buttons_t    buttons;
  accel_t      accel_data;
  accel_t      accel_end_of_frame;
  hcount_t     h_coord;
  coord_t      v_coord;
  logic [2:0]  sw;
  rgb_t        rgb;
  logic [1:0]  demo_regime_status;
  logic [31:0] lfsr_state;
  buttons_t    frame_buttons;  // Held for a whole frame
  accel_t      frame_accel;
  logic [2:0]  frame_sw;

  `include "game_tb_checks.svh"

  game_top game_top_inst (
    .pixel_clk          (pixel_clk),
    .rst_n              (rst_n),
    .button_c           (button_c),
    .buttons            (buttons),
    .accel_data         (accel_data),
    .accel_end_of_frame (accel_end_of_frame),
    .h_coord            (h_coord),
    .v_coord            (v_coord),
    .sw                 (sw),
    .rgb                (rgb),
    .demo_regime_status (demo_regime_status)
  );

  initial begin
    pixel_clk = 1'b0;
    forever #(CLK_PERIOD / 2) pixel_clk = ~pixel_clk;
  end

  initial begin : watchdog
    #(N_FRAMES * FRAME_CYCLES * CLK_PERIOD + 1000);
    $display("Watchdog expired before all frames were driven");
    $display("Test failed");
    $fatal(1, "Simulation timeout");
  end

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
      val = {val[30:0], lfsr_bit()};
    return val;
  endfunction

  // Favoured value 15 times in 16
  function automatic logic leaning_bit(logic favour);
    logic [3:0] r;
    r = 4'(rand_bits(4));
    return favour ? (r != 4'd0) : (r == 4'd0);
  endfunction

  // Check what the last edge produced, then drive the next pixel
  task automatic pixel_cycle(hcount_t h, coord_t v, logic c);
    @(negedge pixel_clk);
    compare_outputs();
    h_coord    = h;
    v_coord    = v;
    button_c   = c;
    buttons    = frame_buttons;
    accel_data = frame_accel;
    sw         = frame_sw;
    model_edge();
  endtask

  initial begin : stimulus
    logic    go_right;
    logic    go_down;
    logic    pulse_c;
    logic    c_level;
    int      probe;
    int      box_h;
    int      box_v;
    hcount_t rh;
    coord_t  rv;
    lfsr_state    = 32'h90ad;
    rst_n         = 1'b0;
    button_c      = 1'b0;
    buttons       = '0;
    accel_data    = '0;
    h_coord       = '0;
    v_coord       = '0;
    sw            = '0;
    frame_buttons = '0;
    frame_accel   = '0;
    frame_sw      = '0;
    model_reset();
    repeat (16) @(posedge pixel_clk);
    @(negedge pixel_clk);
    compare_outputs();  // Reset values
    rst_n = 1'b1;
    model_edge();
    for (int f = 0; f < N_FRAMES; f++) begin
      go_right = (f < N_FRAMES / 2);  // Towards the right edge first
      go_down  = (f < N_FRAMES / 4);  // Bottom edge soon, top edge later
      frame_buttons.up    = leaning_bit(!go_down);
      frame_buttons.down  = leaning_bit(go_down);
      frame_buttons.left  = leaning_bit(!go_right);
      frame_buttons.right = leaning_bit(go_right);
      frame_accel.x       = 8'(rand_bits(8));
      frame_accel.x[7]    = !leaning_bit(go_down);  // Positive x moves down
      frame_accel.y       = 8'(rand_bits(8));
      frame_accel.y[7]    = leaning_bit(go_right);  // Negative y moves right
      frame_sw            = 3'(rand_bits(3));
      pulse_c             = (rand_bits(3) == 0);
      pixel_cycle(hcount_t'(`GAME_H_LAST), coord_t'(`GAME_V_LAST), 1'b0);
      probe = 0;
      for (int s = 0; s < SLOTS; s++) begin
        c_level = pulse_c && (s >= 3) && (s < 8);
        if (s % 3 == 2) begin
          // Extra frame ends let both boxes reach the screen edges
          rh = hcount_t'(rand_bits(11));
          rv = coord_t'(rand_bits(10));
          if (rand_bits(3) != 0)
            pixel_cycle(hcount_t'(`GAME_H_LAST), coord_t'(`GAME_V_LAST), c_level);
          else
            pixel_cycle(rh, rv, c_level);
        end else begin
          box_h = (probe < 8) ? m_player_h : m_enemy_h;
          box_v = (probe < 8) ? m_player_v : `GAME_ENEMY_V;
          pixel_cycle(hcount_t'(box_h + PROBE_DH[probe % 8]),
                      coord_t'(box_v + PROBE_DV[probe % 8]), c_level);
          probe++;
        end
      end
    end
    @(negedge pixel_clk);
    compare_outputs();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== verilog/game_top.sv ====
`timescale 1ns/10ps

module game_top (
  input  logic               pixel_clk,
  input  logic               rst_n,
  input  logic               button_c,            // Regime toggle
  input  game_pkg::buttons_t buttons,
  input  game_pkg::accel_t   accel_data,
  output game_pkg::accel_t   accel_end_of_frame,
  input  game_pkg::hcount_t  h_coord,
  input  game_pkg::coord_t   v_coord,
  input  logic [2:0]         sw,                  // Background colour
  output game_pkg::rgb_t     rgb,
  output logic [1:0]         demo_regime_status
);
  import game_pkg::*;

  logic    action_step;
  regime_e regime;
  accel_t  accel_corr;
  pos_t    player_pos;
  pos_t    enemy_pos;

  assign demo_regime_status = regime;  // 3 buttons, 2 accelerometer

  frame_timer frame_timer_inst (
    .pixel_clk   (pixel_clk),
    .rst_n       (rst_n),
    .h_coord     (h_coord),
    .v_coord     (v_coord),
    .action_step (action_step)
  );

  mode_control mode_control_inst (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .button_c  (button_c),
    .regime    (regime)
  );

  accel_sampler accel_sampler_inst (
    .pixel_clk          (pixel_clk),
    .rst_n              (rst_n),
    .action_step        (action_step),
    .accel_raw          (accel_data),
    .accel_corr         (accel_corr),
    .accel_end_of_frame (accel_end_of_frame)
  );

  player_motion player_motion_inst (
    .pixel_clk   (pixel_clk),
    .rst_n       (rst_n),
    .action_step (action_step),
    .regime      (regime),
    .buttons     (buttons),
    .accel_corr  (accel_corr),
    .player_pos  (player_pos)
  );

  enemy_patrol enemy_patrol_inst (
    .pixel_clk   (pixel_clk),
    .rst_n       (rst_n),
    .action_step (action_step),
    .enemy_pos   (enemy_pos)
  );

  pixel_compositor pixel_compositor_inst (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .h_coord    (h_coord),
    .v_coord    (v_coord),
    .player_pos (player_pos),
    .enemy_pos  (enemy_pos),
    .sw         (sw),
    .rgb        (rgb)
  );

endmodule

// ==== verilog/pixel_compositor.sv ====
`timescale 1ns/10ps
`include "game_defs.svh"

module pixel_compositor (
  input  logic              pixel_clk,
  input  logic              rst_n,
  input  game_pkg::hcount_t h_coord,
  input  game_pkg::coord_t  v_coord,
  input  game_pkg::pos_t    player_pos,
  input  game_pkg::pos_t    enemy_pos,
  input  logic [2:0]        sw,
  output game_pkg::rgb_t    rgb
);
  import game_pkg::*;

  localparam rgb_t PLAYER_RGB = rgb_t'(`GAME_PLAYER_RGB);
  localparam rgb_t ENEMY_RGB  = rgb_t'(`GAME_ENEMY_RGB);

  coord_t pix_h;
  logic   player_hit;
  logic   enemy_hit;
  rgb_t   bg_rgb;
  rgb_t   next_rgb;

  // Box spans corner to corner plus size, both ends included
  function automatic logic in_box(coord_t ph, coord_t pv, pos_t box);
    return (ph >= box.h) && ({1'b0, ph} <= {1'b0, box.h} + 11'(`GAME_SPRITE_SIZE)) &&
           (pv >= box.v) && ({1'b0, pv} <= {1'b0, box.v} + 11'(`GAME_SPRITE_SIZE));
  endfunction

  assign pix_h      = h_coord[9:0];
  assign player_hit = in_box(pix_h, v_coord, player_pos);
  assign enemy_hit  = in_box(pix_h, v_coord, enemy_pos);

  assign bg_rgb.red   = sw[0] ? 4'(`GAME_BG_LEVEL) : 4'h0;
  assign bg_rgb.green = sw[1] ? 4'(`GAME_BG_LEVEL) : 4'h0;
  assign bg_rgb.blue  = sw[2] ? 4'(`GAME_BG_LEVEL) : 4'h0;

  // Player on top, then enemy
  always_comb begin
    if (player_hit)
      next_rgb = PLAYER_RGB;
    else if (enemy_hit)
      next_rgb = ENEMY_RGB;
    else
      next_rgb = bg_rgb;
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      rgb <= '0;
    end else begin
      rgb <= next_rgb;
    end
  end

endmodule

// ==== verilog/enemy_patrol.sv ====
`timescale 1ns/10ps
`include "game_defs.svh"

module enemy_patrol (
  input  logic           pixel_clk,
  input  logic           rst_n,
  input  logic           action_step,
  output game_pkg::pos_t enemy_pos
);
  import game_pkg::*;

  localparam coord_t H_MAX = coord_t'(`GAME_H_LAST - `GAME_SPRITE_SIZE);

  patrol_dir_e dir;
  coord_t      enemy_h;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      dir     <= DIR_LEFT;
      enemy_h <= coord_t'(`GAME_ENEMY_H0);
    end else if (action_step) begin
      if (dir == DIR_LEFT) begin
        // Turn only once the left edge is reached
        if (enemy_h == '0)
          dir <= DIR_RIGHT;
        else
          enemy_h <= enemy_h - 1'b1;
      end else begin
        // Right edge is reached and turned at in the same step
        if (enemy_h >= H_MAX - 1'b1) begin
          enemy_h <= H_MAX;
          dir     <= DIR_LEFT;
        end else begin
          enemy_h <= enemy_h + 1'b1;
        end
      end
    end
  end

  assign enemy_pos = '{h: enemy_h, v: coord_t'(`GAME_ENEMY_V)};  // Row never changes

endmodule

// ==== verilog/player_motion.sv ====
`timescale 1ns/10ps
`include "game_defs.svh"

module player_motion (
  input  logic               pixel_clk,
  input  logic               rst_n,
  input  logic               action_step,
  input  game_pkg::regime_e  regime,
  input  game_pkg::buttons_t buttons,
  input  game_pkg::accel_t   accel_corr,
  output game_pkg::pos_t     player_pos
);
  import game_pkg::*;

  // Largest corner that keeps the box on screen
  localparam coord_t H_MAX = coord_t'(`GAME_H_LAST - `GAME_SPRITE_SIZE);
  localparam coord_t V_MAX = coord_t'(`GAME_V_LAST - `GAME_SPRITE_SIZE);

  buttons_t move_req;

  // One pixel step on one axis, clamped to [0, c_max]
  function automatic coord_t step_axis(coord_t c, logic dec, logic inc, coord_t c_max);
    if (dec)
      return (c == '0) ? '0 : c - 1'b1;
    else if (inc)
      return (c >= c_max) ? c_max : c + 1'b1;
    else
      return c;
  endfunction

  always_comb begin
    move_req = '0;
    case (regime)
      REGIME_BUTTONS: begin
        move_req.left  = buttons.left;
        move_req.right = buttons.right && !buttons.left;  // Left wins
        move_req.up    = buttons.up;
        move_req.down  = buttons.down && !buttons.up;     // Up wins
      end
      REGIME_ACCEL: begin
        // Board tilt, y steers horizontally and x vertically
        move_req.left  = !accel_corr.y[7] && (accel_corr.y != '0);
        move_req.right = accel_corr.y[7];
        move_req.up    = accel_corr.x[7];
        move_req.down  = !accel_corr.x[7] && (accel_corr.x != '0);
      end
      default: move_req = '0;
    endcase
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      player_pos <= '{h: coord_t'(`GAME_PLAYER_H0), v: coord_t'(`GAME_PLAYER_V0)};
    end else if (action_step) begin
      player_pos.h <= step_axis(player_pos.h, move_req.left, move_req.right, H_MAX);
      player_pos.v <= step_axis(player_pos.v, move_req.up, move_req.down, V_MAX);
    end
  end

endmodule

// ==== verilog/accel_sampler.sv ====
`timescale 1ns/10ps
`include "game_defs.svh"

module accel_sampler (
  input  logic             pixel_clk,
  input  logic             rst_n,
  input  logic             action_step,
  input  game_pkg::accel_t accel_raw,
  output game_pkg::accel_t accel_corr,
  output game_pkg::accel_t accel_end_of_frame
);

  // Sensor offsets, wrapping in 8 bits
  assign accel_corr.x = accel_raw.x + 8'(`GAME_ACCEL_X_CORR);
  assign accel_corr.y = accel_raw.y + 8'(`GAME_ACCEL_Y_CORR);

  // Holds the value the last move was based on
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      accel_end_of_frame <= '0;
    end else if (action_step) begin
      accel_end_of_frame <= accel_corr;
    end
  end

endmodule

// ==== verilog/mode_control.sv ====
`timescale 1ns/10ps

module mode_control (
  input  logic              pixel_clk,
  input  logic              rst_n,
  input  logic              button_c,
  output game_pkg::regime_e regime
);
  import game_pkg::*;

  logic button_c_prev;
  logic toggle;

  assign toggle = button_c && !button_c_prev;  // Rising edge

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      button_c_prev <= 1'b0;
    end else begin
      button_c_prev <= button_c;
    end
  end

  // Only two regimes so far, each edge swaps them
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      regime <= REGIME_BUTTONS;
    end else if (toggle) begin
      if (regime == REGIME_BUTTONS)
        regime <= REGIME_ACCEL;
      else
        regime <= REGIME_BUTTONS;
    end
  end

endmodule

// ==== verilog/frame_timer.sv ====
`timescale 1ns/10ps
`include "game_defs.svh"

module frame_timer (
  input  logic              pixel_clk,
  input  logic              rst_n,
  input  game_pkg::hcount_t h_coord,
  input  game_pkg::coord_t  v_coord,
  output logic              action_step
);
  import game_pkg::*;

  localparam int CNT_W = $clog2(`GAME_FRAMES_PER_ACTION + 1);

  logic             end_of_frame;  // Last visible pixel was seen
  logic [CNT_W-1:0] frame_cnt;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      end_of_frame <= 1'b0;
    end else begin
      end_of_frame <= (h_coord[9:0] == coord_t'(`GAME_H_LAST)) &&
                      (v_coord == coord_t'(`GAME_V_LAST));
    end
  end

  // Wraps after GAME_FRAMES_PER_ACTION
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      frame_cnt <= '0;
    end else if (end_of_frame) begin
      if (frame_cnt == CNT_W'(`GAME_FRAMES_PER_ACTION))
        frame_cnt <= '0;
      else
        frame_cnt <= frame_cnt + 1'b1;
    end
  end

  assign action_step = end_of_frame && (frame_cnt == '0);  // First frame after reset acts

endmodule

// ==== verilog/game_pkg.sv ====
package game_pkg;

  // Visible screen coordinate
  typedef logic [9:0] coord_t;

  // Horizontal counter as delivered by the video timing
  typedef logic [10:0] hcount_t;

  // Top-left corner of a box
  typedef struct packed {
    coord_t h;
    coord_t v;
  } pos_t;

  // Also used as a move request
  typedef struct packed {
    logic up;
    logic down;
    logic left;
    logic right;
  } buttons_t;

  // Two's complement readings
  typedef struct packed {
    logic [7:0] x;
    logic [7:0] y;
  } accel_t;

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_t;

  // Encoding doubles as the reported status
  typedef enum logic [1:0] {
    REGIME_ACCEL   = 2'd2,
    REGIME_BUTTONS = 2'd3
  } regime_e;

  typedef enum logic {
    DIR_LEFT  = 1'b0,
    DIR_RIGHT = 1'b1
  } patrol_dir_e;

endpackage

// ==== verilog/game_defs.svh ====
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// Visible area of the 800x600 mode
`define GAME_H_LAST 799
`define GAME_V_LAST 599

// Both boxes are square
`define GAME_SPRITE_SIZE 128

// Accelerometer zero offsets, added modulo 256
`define GAME_ACCEL_X_CORR 3
`define GAME_ACCEL_Y_CORR 1

// Action step every (N + 1) frames
`define GAME_FRAMES_PER_ACTION 2

// Player starts near the screen centre
`define GAME_PLAYER_H0 399
`define GAME_PLAYER_V0 299

// Enemy patrols a fixed row
`define GAME_ENEMY_H0 299
`define GAME_ENEMY_V 355

// Box colours as {red, green, blue}
`define GAME_PLAYER_RGB 12'hFA0
`define GAME_ENEMY_RGB 12'h0CF

// Per-channel level for an active background switch
`define GAME_BG_LEVEL 8

`endif
